// File: Makefile
VERILATOR = verilator
TB_TOP = fetch_decode_tb
DUT_TOP = fetch_decode
FLIST = flist.f
OBJ_DIR = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert -j 0
PASS_MSG = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FLIST)

$(OBJ_DIR)/$(TB_TOP):
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)

sim: $(OBJ_DIR)/$(TB_TOP)
	@out=$$(./$(OBJ_DIR)/$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

.DELETE_ON_ERROR:

// File: flist.f
hdl/fd_pkg.sv
hdl/warp_pc.sv
hdl/dual_grant_arbiter.sv
hdl/icache_mem.sv
hdl/instr_decoder.sv
hdl/fetch_decode.sv
verif/fetch_decode_tb.sv

// File: hdl/dual_grant_arbiter.sv
module dual_grant_arbiter (
	input logic clk,
	input logic rst_n,
	input logic [fd_pkg::num_warps-1:0] eligible,
	output logic [fd_pkg::num_warps-1:0] grant0,
	output logic [fd_pkg::num_warps-1:0] grant1
);

	logic [fd_pkg::num_warps-1:0] rotated;
	fd_pkg::warp_id_t ptr;
	fd_pkg::warp_id_t off0;
	fd_pkg::warp_id_t off1;
	fd_pkg::warp_id_t win0;
	fd_pkg::warp_id_t win1;
	logic found0;
	logic found1;

	// Bit 0 of rotated is the warp at the pointer
	assign rotated = (eligible >> ptr) | (eligible << (fd_pkg::num_warps - ptr));

	always_comb begin
		found0 = 1'b0;
		found1 = 1'b0;
		off0 = '0;
		off1 = '0;
		for (int i = 0; i < fd_pkg::num_warps; i++) begin
			if (rotated[i]) begin
				if (!found0) begin
					found0 = 1'b1;
					off0 = fd_pkg::warp_id_t'(i);
				end else if (!found1) begin
					found1 = 1'b1;
					off1 = fd_pkg::warp_id_t'(i);
				end
			end
		end
	end

	// Offsets back to absolute warp numbers modulo num_warps
	assign win0 = ptr + off0;
	assign win1 = ptr + off1;

	always_comb begin
		grant0 = '0;
		grant1 = '0;
		grant0[win0] = found0;
		grant1[win1] = found1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			ptr <= '0;
		else if (found1)
			ptr <= win1 + 1'b1;
		else if (found0)
			ptr <= win0 + 1'b1;
	end

	assert property (@(posedge clk) disable iff (!rst_n) (grant0 & grant1) == '0)
		else $error("dual_grant_arbiter: overlapping grants");

endmodule

// File: hdl/fd_pkg.sv
package fd_pkg;

	localparam int num_warps = 8;
	localparam int warp_w = $clog2(num_warps);
	localparam int ib_depth = 2; // Entries per warp in the instruction buffer
	localparam int credit_w = $clog2(ib_depth + 1);
	localparam int icache_aw = 10;
	localparam int icache_words = 1 << icache_aw;
	localparam int instr_w = 32;
	localparam int pc_w = 32;
	localparam int reg_w = 5;
	localparam int imm_w = 16;

	// Instruction field layout
	localparam int op_hi = 31;
	localparam int op_lo = 26;
	localparam int dst_hi = 25;
	localparam int dst_lo = 21;
	localparam int src1_hi = 20;
	localparam int src1_lo = 16;
	localparam int src2_hi = 15;
	localparam int src2_lo = 11;
	localparam int imm_hi = 15;
	localparam int imm_lo = 0;

	typedef logic [warp_w-1:0] warp_id_t;

	typedef enum logic [5:0] {
		op_nop  = 6'h00,
		op_add  = 6'h01,
		op_sub  = 6'h02,
		op_and  = 6'h03,
		op_or   = 6'h04,
		op_addi = 6'h05,
		op_lw   = 6'h06,
		op_sw   = 6'h07,
		op_beq  = 6'h08,
		op_blt  = 6'h09,
		op_jmp  = 6'h0a,
		op_exit = 6'h0b
	} opcode_e;

	typedef enum logic [3:0] {
		alu_pass = 4'h0,
		alu_add  = 4'h1,
		alu_sub  = 4'h2,
		alu_and  = 4'h3,
		alu_or   = 4'h4,
		alu_cmp  = 4'h5
	} alu_op_e;

	typedef struct packed {
		logic valid;
		warp_id_t warp;
		logic [pc_w-1:0] pc;
	} warp_start_t;

	typedef struct packed {
		logic we;
		logic [icache_aw-1:0] addr;
		logic [instr_w-1:0] wdata;
	} fio_req_t;

	typedef struct packed {
		logic valid;
		warp_id_t warp;
		logic [pc_w-1:0] pc_plus4;
	} fetch_slot_t;

	typedef struct packed {
		logic valid;
		logic [num_warps-1:0] warp; // One-hot
		logic [instr_w-1:0] instr;
		logic [pc_w-1:0] pc_plus4;
		logic [reg_w-1:0] src1;
		logic [reg_w-1:0] src2;
		logic [reg_w-1:0] dst;
		logic [imm_w-1:0] imm;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic src1_valid;
		logic src2_valid;
		logic imm_valid;
		alu_op_e alu_op;
		logic beq;
		logic blt;
		logic jmp;
		logic exit;
	} decoded_t;

	typedef struct packed {
		logic valid;
		warp_id_t warp;
		logic [pc_w-1:0] target;
	} redirect_t;

endpackage

// File: hdl/fetch_decode.sv
module fetch_decode (
	input logic clk,
	input logic rst_n,
	input fd_pkg::fio_req_t fio,
	input fd_pkg::warp_start_t warp_start,
	input logic [fd_pkg::num_warps-1:0] credit_return,
	output logic [fd_pkg::instr_w-1:0] fio_rdata,
	output fd_pkg::decoded_t ib_out [2]
);

	logic [fd_pkg::pc_w-1:0] pc [fd_pkg::num_warps];
	logic [fd_pkg::num_warps-1:0] eligible;
	logic [fd_pkg::num_warps-1:0] done_strobe;
	logic [fd_pkg::num_warps-1:0] exit_strobe;
	logic [fd_pkg::num_warps-1:0] lane_grant [2]; // Lane 0 has priority
	fd_pkg::warp_id_t lane_warp [2];
	logic [fd_pkg::icache_aw-1:0] lane_addr [2];
	logic [fd_pkg::instr_w-1:0] lane_instr [2];
	fd_pkg::fetch_slot_t slot_d [2];
	fd_pkg::fetch_slot_t slot_q [2];
	fd_pkg::decoded_t dec [2];
	fd_pkg::redirect_t redir [2];
	fd_pkg::redirect_t warp_redir [fd_pkg::num_warps];

	for (genvar w = 0; w < fd_pkg::num_warps; w++) begin : g_warp
		assign done_strobe[w] = dec[0].warp[w] | dec[1].warp[w];
		assign exit_strobe[w] = (dec[0].warp[w] & dec[0].exit) | (dec[1].warp[w] & dec[1].exit);

		// Both lanes never carry the same warp
		always_comb begin
			warp_redir[w] = redir[0];
			warp_redir[w].valid = redir[0].valid && redir[0].warp == fd_pkg::warp_id_t'(w);
			if (redir[1].valid && redir[1].warp == fd_pkg::warp_id_t'(w))
				warp_redir[w] = redir[1];
		end

		warp_pc u_warp_pc (
			.clk(clk),
			.rst_n(rst_n),
			.start(warp_start.valid && warp_start.warp == fd_pkg::warp_id_t'(w)),
			.start_pc(warp_start.pc),
			.grant(lane_grant[0][w] | lane_grant[1][w]),
			.credit_in(credit_return[w]),
			.redirect(warp_redir[w]),
			.done(done_strobe[w]),
			.is_exit(exit_strobe[w]),
			.pc(pc[w]),
			.eligible(eligible[w])
		);
	end

	dual_grant_arbiter u_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.eligible(eligible),
		.grant0(lane_grant[0]),
		.grant1(lane_grant[1])
	);

	icache_mem u_icache (
		.clk(clk),
		.fio(fio),
		.rd_addr0(lane_addr[0]),
		.rd_addr1(lane_addr[1]),
		.fio_rdata(fio_rdata),
		.rd_data0(lane_instr[0]),
		.rd_data1(lane_instr[1])
	);

	for (genvar l = 0; l < 2; l++) begin : g_lane
		always_comb begin
			lane_warp[l] = '0;
			for (int w = 0; w < fd_pkg::num_warps; w++)
				if (lane_grant[l][w])
					lane_warp[l] = fd_pkg::warp_id_t'(w);
		end

		assign lane_addr[l] = pc[lane_warp[l]][fd_pkg::icache_aw+1:2];
		assign slot_d[l].valid = |lane_grant[l];
		assign slot_d[l].warp = lane_warp[l];
		assign slot_d[l].pc_plus4 = pc[lane_warp[l]] + 32'd4;

		// Fetch stage registers aligned with the cache read
		always_ff @(posedge clk) begin
			slot_q[l] <= slot_d[l];
			if (!rst_n)
				slot_q[l].valid <= 1'b0;
		end

		instr_decoder u_decoder (
			.slot(slot_q[l]),
			.instr(lane_instr[l]),
			.dec(dec[l]),
			.redirect(redir[l])
		);

		always_ff @(posedge clk) begin
			ib_out[l] <= dec[l];
			if (!rst_n)
				ib_out[l].valid <= 1'b0;
		end
	end

endmodule

// File: hdl/icache_mem.sv
module icache_mem (
	input logic clk,
	input fd_pkg::fio_req_t fio,
	input logic [fd_pkg::icache_aw-1:0] rd_addr0,
	input logic [fd_pkg::icache_aw-1:0] rd_addr1,
	output logic [fd_pkg::instr_w-1:0] fio_rdata,
	output logic [fd_pkg::instr_w-1:0] rd_data0,
	output logic [fd_pkg::instr_w-1:0] rd_data1
);

	logic [fd_pkg::instr_w-1:0] mem [fd_pkg::icache_words];

	// Loader port
	always_ff @(posedge clk) begin
		if (fio.we)
			mem[fio.addr] <= fio.wdata;
		else
			fio_rdata <= mem[fio.addr];
	end

	// One word per granted warp on each fetch lane
	always_ff @(posedge clk) begin
		rd_data0 <= mem[rd_addr0];
		rd_data1 <= mem[rd_addr1];
	end

endmodule

// File: hdl/instr_decoder.sv
module instr_decoder (
	input fd_pkg::fetch_slot_t slot,
	input logic [fd_pkg::instr_w-1:0] instr,
	output fd_pkg::decoded_t dec,
	output fd_pkg::redirect_t redirect
);

	fd_pkg::opcode_e opcode;
	logic [fd_pkg::imm_w-1:0] imm;
	logic [fd_pkg::pc_w-1:0] offset;

	assign opcode = fd_pkg::opcode_e'(instr[fd_pkg::op_hi:fd_pkg::op_lo]);
	assign imm = instr[fd_pkg::imm_hi:fd_pkg::imm_lo];
	// Word offset, sign extended
	assign offset = {{(fd_pkg::pc_w - fd_pkg::imm_w - 2){imm[fd_pkg::imm_w-1]}}, imm, 2'b00};

	always_comb begin
		dec = '0;
		dec.valid = slot.valid;
		dec.warp[slot.warp] = slot.valid;
		dec.instr = instr;
		dec.pc_plus4 = slot.pc_plus4;
		dec.src1 = instr[fd_pkg::src1_hi:fd_pkg::src1_lo];
		dec.src2 = instr[fd_pkg::src2_hi:fd_pkg::src2_lo];
		dec.dst = instr[fd_pkg::dst_hi:fd_pkg::dst_lo];
		dec.imm = imm;
		dec.alu_op = fd_pkg::alu_pass;
		case (opcode)
			fd_pkg::op_add, fd_pkg::op_sub, fd_pkg::op_and, fd_pkg::op_or: begin
				dec.reg_write = 1'b1;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				case (opcode)
					fd_pkg::op_sub: dec.alu_op = fd_pkg::alu_sub;
					fd_pkg::op_and: dec.alu_op = fd_pkg::alu_and;
					fd_pkg::op_or: dec.alu_op = fd_pkg::alu_or;
					default: dec.alu_op = fd_pkg::alu_add;
				endcase
			end
			fd_pkg::op_addi, fd_pkg::op_lw: begin
				dec.reg_write = 1'b1;
				dec.src1_valid = 1'b1;
				dec.imm_valid = 1'b1;
				dec.mem_read = opcode == fd_pkg::op_lw;
				dec.alu_op = fd_pkg::alu_add; // Address add for LW
			end
			fd_pkg::op_sw: begin
				dec.mem_write = 1'b1;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1; // Store data
				dec.imm_valid = 1'b1;
				dec.alu_op = fd_pkg::alu_add;
			end
			fd_pkg::op_beq, fd_pkg::op_blt: begin
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.imm_valid = 1'b1;
				dec.alu_op = fd_pkg::alu_cmp;
				dec.beq = opcode == fd_pkg::op_beq;
				dec.blt = opcode == fd_pkg::op_blt;
			end
			fd_pkg::op_jmp: begin
				dec.imm_valid = 1'b1;
				dec.jmp = 1'b1;
			end
			fd_pkg::op_exit: dec.exit = 1'b1;
			default: ; // NOP and unknown codes
		endcase
	end

	assign redirect.valid = slot.valid && dec.jmp;
	assign redirect.warp = slot.warp;
	assign redirect.target = slot.pc_plus4 + offset;

endmodule

// File: hdl/warp_pc.sv
module warp_pc (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [fd_pkg::pc_w-1:0] start_pc,
	input logic grant,
	input logic credit_in,
	input fd_pkg::redirect_t redirect,
	input logic done,
	input logic is_exit,
	output logic [fd_pkg::pc_w-1:0] pc,
	output logic eligible
);

	logic active;
	logic in_flight;
	logic [fd_pkg::credit_w-1:0] credits;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			in_flight <= 1'b0;
			credits <= fd_pkg::credit_w'(fd_pkg::ib_depth);
		end else if (start) begin
			active <= 1'b1;
			in_flight <= 1'b0;
			credits <= fd_pkg::credit_w'(fd_pkg::ib_depth); // Buffer drained for a new task
		end else begin
			if (grant)
				in_flight <= 1'b1;
			else if (done) begin
				in_flight <= 1'b0;
				if (is_exit)
					active <= 1'b0;
			end
			// Return and spend in one cycle cancel
			case ({grant, credit_in})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			pc <= start_pc;
		else if (redirect.valid)
			pc <= redirect.target; // JMP resolved in decode
		else if (grant)
			pc <= pc + 32'd4;
	end

	assign eligible = active && !in_flight && credits != '0;

	// Underflow wraps to a value above ib_depth
	assert property (@(posedge clk) disable iff (!rst_n)
		credits <= fd_pkg::credit_w'(fd_pkg::ib_depth))
		else $error("warp_pc: credit count out of range");

	assert property (@(posedge clk) disable iff (!rst_n) grant |-> eligible)
		else $error("warp_pc: grant to an ineligible warp");

	assert property (@(posedge clk) disable iff (!rst_n) start |-> !active)
		else $error("warp_pc: start on an active warp");

endmodule

// File: verif/fetch_decode_tb.sv
module fetch_decode_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [15:0] pc; // Byte address
		logic [5:0] op;
		logic [4:0] dst;
		logic [4:0] src1;
		logic [15:0] imm; // Top five bits double as src2
		logic [3:0] alu;
		logic [9:0] flags; // reg_write down to exit in decoded_t order
	} row_t;

	typedef struct packed {
		fd_pkg::warp_id_t warp;
		logic [31:0] pc;
	} start_t;

	localparam logic [9:0] f_none = 10'b0000000000;
	localparam logic [9:0] f_rrr = 10'b1001100000;
	localparam logic [9:0] f_addi = 10'b1001010000;
	localparam logic [9:0] f_lw = 10'b1101010000;
	localparam logic [9:0] f_sw = 10'b0011110000;
	localparam logic [9:0] f_beq = 10'b0001111000;
	localparam logic [9:0] f_blt = 10'b0001110100;
	localparam logic [9:0] f_jmp = 10'b0000010010;
	localparam logic [9:0] f_exit = 10'b0000000001;

	localparam int num_rows = 27;
	localparam int timeout_ns = num_rows * 40 * 8;

	row_t prog [num_rows] = '{
		'{16'h0100, fd_pkg::op_add, 5'd1, 5'd2, 16'h1800, fd_pkg::alu_add, f_rrr},
		'{16'h0104, fd_pkg::op_sub, 5'd4, 5'd1, 16'h2800, fd_pkg::alu_sub, f_rrr},
		'{16'h0108, fd_pkg::op_jmp, 5'd0, 5'd0, 16'h0002, fd_pkg::alu_pass, f_jmp},
		'{16'h010c, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit}, // Skipped
		'{16'h0110, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit}, // Skipped
		'{16'h0114, fd_pkg::op_lw, 5'd6, 5'd1, 16'h0010, fd_pkg::alu_add, f_lw},
		'{16'h0118, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit},
		'{16'h0200, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit},
		'{16'h0204, fd_pkg::op_addi, 5'd2, 5'd2, 16'hfff0, fd_pkg::alu_add, f_addi},
		'{16'h0208, fd_pkg::op_sw, 5'd0, 5'd1, 16'h3804, fd_pkg::alu_add, f_sw},
		'{16'h020c, fd_pkg::op_jmp, 5'd0, 5'd0, 16'hfffc, fd_pkg::alu_pass, f_jmp}, // Backward
		'{16'h0300, fd_pkg::op_beq, 5'd0, 5'd1, 16'h1003, fd_pkg::alu_cmp, f_beq},
		'{16'h0304, fd_pkg::op_blt, 5'd0, 5'd3, 16'h27fe, fd_pkg::alu_cmp, f_blt},
		'{16'h0308, fd_pkg::op_or, 5'd8, 5'd9, 16'h5000, fd_pkg::alu_or, f_rrr},
		'{16'h030c, fd_pkg::op_and, 5'd11, 5'd12, 16'h6800, fd_pkg::alu_and, f_rrr},
		'{16'h0310, fd_pkg::op_nop, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_none},
		'{16'h0314, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit},
		'{16'h0400, 6'h3f, 5'd31, 5'd31, 16'hffff, fd_pkg::alu_pass, f_none}, // Unknown code
		'{16'h0404, fd_pkg::op_add, 5'd1, 5'd1, 16'h0800, fd_pkg::alu_add, f_rrr},
		'{16'h0408, fd_pkg::op_addi, 5'd1, 5'd1, 16'h0001, fd_pkg::alu_add, f_addi},
		'{16'h040c, fd_pkg::op_lw, 5'd2, 5'd1, 16'h0004, fd_pkg::alu_add, f_lw},
		'{16'h0410, fd_pkg::op_sw, 5'd0, 5'd1, 16'h1008, fd_pkg::alu_add, f_sw},
		'{16'h0414, fd_pkg::op_sub, 5'd3, 5'd2, 16'h0800, fd_pkg::alu_sub, f_rrr},
		'{16'h0418, fd_pkg::op_jmp, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_jmp},
		'{16'h041c, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit},
		'{16'h0500, fd_pkg::op_addi, 5'd5, 5'd0, 16'h8000, fd_pkg::alu_add, f_addi},
		'{16'h0504, fd_pkg::op_exit, 5'd0, 5'd0, 16'h0000, fd_pkg::alu_pass, f_exit}
	};

	// Last entry restarts warp 0 after its first program exits
	start_t starts [5] = '{
		'{3'd0, 32'h0100}, '{3'd5, 32'h0204}, '{3'd2, 32'h0300}, '{3'd7, 32'h0400},
		'{3'd0, 32'h0500}
	};

	logic clk;
	logic rst_n;
	fd_pkg::fio_req_t fio;
	fd_pkg::warp_start_t warp_start;
	logic [fd_pkg::num_warps-1:0] credit_return;
	logic [fd_pkg::instr_w-1:0] fio_rdata;
	fd_pkg::decoded_t ib_out [2];

	logic [31:0] exp_pc [fd_pkg::num_warps][$]; // Walked program order per warp
	int consumed [fd_pkg::num_warps];
	int received [fd_pkg::num_warps];
	int returned [fd_pkg::num_warps];
	int wait_left [fd_pkg::num_warps];
	logic [fd_pkg::num_warps-1:0] hold;

	fetch_decode uut (
		.clk(clk),
		.rst_n(rst_n),
		.fio(fio),
		.warp_start(warp_start),
		.credit_return(credit_return),
		.fio_rdata(fio_rdata),
		.ib_out(ib_out)
	);

	function automatic logic [31:0] instr_word(input row_t r);
		return {r.op, r.dst, r.src1, r.imm};
	endfunction

	function automatic int find_row(input logic [31:0] pc);
		for (int i = 0; i < num_rows; i++)
			if ({16'h0, prog[i].pc} == pc)
				return i;
		return -1;
	endfunction

	function automatic bit all_done();
		for (int w = 0; w < fd_pkg::num_warps; w++)
			if (consumed[w] != exp_pc[w].size())
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic end_with_failure();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
			end_with_failure();
		end
	endtask

	// Follows the program from its start PC up to EXIT
	task automatic walk_program(input fd_pkg::warp_id_t w, input logic [31:0] start_pc);
		logic [31:0] pc;
		int idx;
		pc = start_pc;
		for (int step = 0; step < 64; step++) begin
			idx = find_row(pc);
			if (idx < 0) begin
				$display("ERROR: program of warp %0d runs to PC %0h outside the table", w, pc);
				end_with_failure();
			end
			exp_pc[w].push_back(pc);
			if (prog[idx].op == fd_pkg::op_exit)
				break;
			if (prog[idx].op == fd_pkg::op_jmp)
				pc = pc + 32'd4 + 32'($signed(prog[idx].imm) * 4);
			else
				pc = pc + 32'd4;
		end
	endtask

	task automatic check_entry(input fd_pkg::decoded_t d, input int slot);
		string tag;
		int w;
		row_t r;
		logic [31:0] pc;
		tag = $sformatf("ib_out[%0d]", slot);
		w = 0;
		check_value({tag, ".warp ones"}, 1, $countones(d.warp));
		for (int i = 0; i < fd_pkg::num_warps; i++)
			if (d.warp[i])
				w = i;
		if (consumed[w] >= exp_pc[w].size()) begin
			$display("ERROR: entry for warp %0d at t=%0t with nothing left to run", w, $time);
			end_with_failure();
		end
		pc = exp_pc[w][consumed[w]];
		r = prog[find_row(pc)];
		consumed[w]++;
		check_value({tag, ".instr"}, instr_word(r), d.instr);
		check_value({tag, ".pc_plus4"}, pc + 32'd4, d.pc_plus4);
		check_value({tag, ".dst"}, r.dst, d.dst);
		check_value({tag, ".src1"}, r.src1, d.src1);
		check_value({tag, ".src2"}, r.imm[15:11], d.src2);
		check_value({tag, ".imm"}, r.imm, d.imm);
		check_value({tag, ".alu_op"}, r.alu, d.alu_op);
		check_value({tag, ".flags"}, r.flags, {d.reg_write, d.mem_read, d.mem_write,
			d.src1_valid, d.src2_valid, d.imm_valid, d.beq, d.blt, d.jmp, d.exit});
		received[w]++;
		check_value($sformatf("warp %0d outstanding <= ib_depth", w), 1,
			received[w] - returned[w] <= fd_pkg::ib_depth);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("ERROR: timeout, not every started warp reached its EXIT");
		end_with_failure();
	end

	// Instruction buffer drain model
	initial begin
		void'($urandom(32'h21e0));
		credit_return = '0;
		for (int w = 0; w < fd_pkg::num_warps; w++)
			wait_left[w] = -1;
		forever begin
			@(posedge clk);
			#1;
			for (int w = 0; w < fd_pkg::num_warps; w++) begin
				credit_return[w] = 1'b0;
				if (rst_n && !hold[w] && received[w] != returned[w]) begin
					if (wait_left[w] < 0)
						wait_left[w] = int'($urandom_range(5, 0));
					if (wait_left[w] == 0) begin
						credit_return[w] = 1'b1;
						returned[w]++;
						wait_left[w] = -1;
					end else
						wait_left[w]--;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			if (ib_out[0].valid && ib_out[1].valid)
				check_value("ib_out slots share a warp", 0, |(ib_out[0].warp & ib_out[1].warp));
			for (int s = 0; s < 2; s++)
				if (ib_out[s].valid)
					check_entry(ib_out[s], s);
		end
	end

	initial begin
		rst_n = 1'b0;
		fio = '0;
		warp_start = '0;
		hold = '0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check_value("ib_out[0].valid", 0, ib_out[0].valid);
		check_value("ib_out[1].valid", 0, ib_out[1].valid);

		for (int i = 0; i < num_rows; i++) begin
			@(posedge clk);
			#1;
			fio.we = 1'b1;
			fio.addr = prog[i].pc[11:2];
			fio.wdata = instr_word(prog[i]);
		end
		for (int i = 0; i < num_rows; i++) begin
			@(posedge clk);
			#1;
			fio.we = 1'b0;
			fio.addr = prog[i].pc[11:2];
			@(posedge clk);
			@(negedge clk);
			check_value("fio_rdata", instr_word(prog[i]), fio_rdata);
		end

		hold[2] = 1'b1; // Back-pressure on two warps
		hold[7] = 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			walk_program(starts[i].warp, starts[i].pc);
			warp_start.valid = 1'b1;
			warp_start.warp = starts[i].warp;
			warp_start.pc = starts[i].pc;
		end
		@(posedge clk);
		#1 warp_start = '0;

		repeat (40) @(posedge clk);
		check_value("warp 2 entries while held", fd_pkg::ib_depth, received[2] - returned[2]);
		check_value("warp 7 entries while held", fd_pkg::ib_depth, received[7] - returned[7]);
		hold = '0;

		while (!all_done())
			@(posedge clk);
		while (received[0] != returned[0])
			@(posedge clk);
		@(posedge clk);
		#1;
		walk_program(starts[4].warp, starts[4].pc);
		warp_start.valid = 1'b1;
		warp_start.warp = starts[4].warp;
		warp_start.pc = starts[4].pc;
		@(posedge clk);
		#1 warp_start = '0;

		while (!all_done())
			@(posedge clk);
		repeat (20) @(posedge clk); // Any stray entry shows up in the monitor
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
